/* compile.f */
source/lsu_pkg.sv
source/load_aligner.sv
source/lsu_dispatch.sv
source/lsu_bank.sv
source/lsu_collector.sv
source/lsu_top.sv
testbench/tb_lsu_properties.sv
testbench/tb_lsu.sv

/* run.sh */
#!/usr/bin/env bash
# Build and run the LSU testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f compile.f; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_lsu)
sim_status=$?
echo "$sim_out"

if [ "$sim_status" -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "Test completed successfully"; then
    exit 0
else
    exit 1
fi

/* testbench/tb_lsu.sv */
module tb_lsu import lsu_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_BANKS   = 4;
    localparam int BANK_DEPTH  = 16;
    localparam int ADDR_W      = 9;
    localparam int CLK_PERIOD  = 100;
    localparam int DRIVE_DELAY = 10;
    localparam int MODEL_ROWS  = NUM_BANKS * BANK_DEPTH;
    localparam int N_RAND      = 60;
    // Zero readback and fill of all rows plus typed loads in two rows and random triples
    localparam int N_REQ       = 2 * MODEL_ROWS + 2 * 7 * 8 + 3 * N_RAND;
    // Up to three idle cycles after each random triple plus margin
    localparam int MAX_CYCLES  = N_REQ + 3 * N_RAND + 4 + 50;

    logic     clk;
    logic     rst_n;
    logic     req_valid;
    lsu_req_t req;
    logic     rsp_valid;
    lsu_rsp_t rsp;

    // Reference memory with one entry per doubleword address
    logic [XLEN-1:0]  model_mem [MODEL_ROWS];
    lsu_rsp_t         exp_q [$];
    int               issue_q [$];
    lsu_rsp_t         exp_rsp;
    int               exp_cycle;
    int               cycle;
    int               checks;
    int               mismatches;
    int               other_errors;
    logic [15:0]      lfsr;
    logic [TAG_W-1:0] next_tag;

    lsu_top #(
        .NUM_BANKS  (NUM_BANKS),
        .BANK_DEPTH (BANK_DEPTH),
        .ADDR_W     (ADDR_W)
    ) dut_i (
        .clk_i       (clk),
        .rst_n_i     (rst_n),
        .req_valid_i (req_valid),
        .req_i       (req),
        .rsp_valid_o (rsp_valid),
        .rsp_o       (rsp)
    );

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    initial cycle = 0;
    always @(posedge clk) cycle <= cycle + 1;

    // ----------------------------------------
    // Random bits and reference model
    // ----------------------------------------
    // Fibonacci LFSR with taps 16 14 13 11 stepped once per bit
    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr = {lfsr[14:0], fb};
            v    = {v[62:0], fb};
        end
        return v;
    endfunction

    function automatic ldst_type_t rand_type();
        logic [2:0] v;
        v = 3'(take_bits(3));
        // Unused code 7 folds onto doubleword
        if (v == 3'd7) v = 3'd6;
        return ldst_type_t'(v);
    endfunction

    // Applies one request to the model and returns the expected response
    function automatic lsu_rsp_t model_access(input lsu_req_t r);
        lsu_rsp_t        e;
        int              size;
        int              off;
        int              idx;
        logic            sgn;
        logic [XLEN-1:0] val;
        e.tag      = r.tag;
        e.is_store = r.is_store;
        e.rdata    = '0;
        off        = int'(r.addr[2:0]);
        idx        = int'(r.addr[ADDR_W-1:3]);
        case (r.ldst_type)
            LS_BYTE, LS_BYTE_U:         size = 1;
            LS_HALFWORD, LS_HALFWORD_U: size = 2;
            LS_WORD, LS_WORD_U:         size = 4;
            default:                    size = 8;
        endcase
        sgn = (r.ldst_type == LS_BYTE) || (r.ldst_type == LS_HALFWORD) ||
              (r.ldst_type == LS_WORD);
        // Natural alignment check leaves memory untouched on a bad access
        e.misaligned = (off % size) != 0;
        if (e.misaligned) return e;
        if (r.is_store) begin
            for (int b = 0; b < size; b++) begin
                model_mem[idx][(off + b) * 8 +: 8] = r.wdata[b * 8 +: 8];
            end
        end else begin
            val = model_mem[idx] >> (off * 8);
            // Fill above the access size
            for (int b = size * 8; b < XLEN; b++) begin
                val[b] = sgn ? val[size * 8 - 1] : 1'b0;
            end
            e.rdata = val;
        end
        return e;
    endfunction

    // ----------------------------------------
    // Drivers
    // ----------------------------------------
    task automatic send_req(input ldst_type_t t, input logic st,
                            input logic [ADDR_W-1:0] a, input logic [XLEN-1:0] d);
        lsu_req_t r;
        r.ldst_type = t;
        r.is_store  = st;
        r.addr      = REQ_ADDR_W'(a);
        r.wdata     = d;
        r.tag       = next_tag;
        next_tag    = next_tag + 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        req_valid = 1'b1;
        req       = r;
        exp_q.push_back(model_access(r));
        issue_q.push_back(cycle);
    endtask

    task automatic idle(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DELAY;
            req_valid = 1'b0;
        end
    endtask

    // Response check halfway through the cycle
    always @(negedge clk) begin
        if (rst_n && rsp_valid) begin
            assert (exp_q.size() != 0) else begin
                other_errors++;
                $display("Response at %0t with no request outstanding", $time);
            end
            if (exp_q.size() != 0) begin
                exp_rsp   = exp_q.pop_front();
                exp_cycle = issue_q.pop_front();
                checks++;
                assert (rsp == exp_rsp) else begin
                    mismatches++;
                    $display("MISMATCH @%0t: tag %0h st %b mis %b data %h",
                             $time, rsp.tag, rsp.is_store, rsp.misaligned, rsp.rdata);
                    $display("    expected tag %0h st %b mis %b data %h",
                             exp_rsp.tag, exp_rsp.is_store, exp_rsp.misaligned,
                             exp_rsp.rdata);
                end
                assert (cycle - exp_cycle == LSU_LATENCY) else begin
                    mismatches++;
                    $display("MISMATCH @%0t: tag %0h came after %0d cycles, expected %0d",
                             $time, rsp.tag, cycle - exp_cycle, LSU_LATENCY);
                end
            end
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        logic [ADDR_W-1:0] a;
        logic [ADDR_W-4:0] row_sel;
        ldst_type_t        t;
        lfsr         = 16'd45;
        next_tag     = '0;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        req_valid    = 1'b0;
        req          = '0;
        rst_n        = 1'b0;
        for (int i = 0; i < MODEL_ROWS; i++) model_mem[i] = '0;
        repeat (4) @(posedge clk);
        #DRIVE_DELAY;
        rst_n = 1'b1;
        // Every row reads zero after reset with loads rotating through the banks
        for (int i = 0; i < MODEL_ROWS; i++) begin
            send_req(LS_DOUBLEWORD, 1'b0, ADDR_W'(i * 8), '0);
        end
        // Fill every row so consecutive doublewords hit different banks
        for (int i = 0; i < MODEL_ROWS; i++) begin
            send_req(LS_DOUBLEWORD, 1'b1, ADDR_W'(i * 8), take_bits(64));
        end
        // Every type at every offset including misaligned ones
        for (int r = 0; r < 2; r++) begin
            row_sel = (ADDR_W - 3)'(take_bits(ADDR_W - 3));
            for (int ty = 0; ty < 7; ty++) begin
                for (int off = 0; off < 8; off++) begin
                    send_req(ldst_type_t'(3'(ty)), 1'b0, {row_sel, 3'(off)}, '0);
                end
            end
        end
        // Store and a load of the same address next cycle followed by the merged row
        for (int i = 0; i < N_RAND; i++) begin
            t = rand_type();
            a = ADDR_W'(take_bits(ADDR_W));
            send_req(t, 1'b1, a, take_bits(64));
            send_req(rand_type(), 1'b0, a, '0);
            send_req(LS_DOUBLEWORD, 1'b0, {a[ADDR_W-1:3], 3'b000}, '0);
            idle(int'(take_bits(2)));
        end
        idle(1);
        while (exp_q.size() != 0) @(posedge clk);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog sized from the request count
    initial begin
        #(MAX_CYCLES * CLK_PERIOD);
        $display("Timeout: %0d responses still outstanding after %0d cycles",
                 exp_q.size(), MAX_CYCLES);
        $display("Test failed");
        $finish;
    end

endmodule

/* testbench/tb_lsu_properties.sv */
module tb_lsu_properties import lsu_pkg::*; #(
    parameter int unsigned NUM_BANKS = 4
) (
    input logic                 clk_i,
    input logic                 rst_n_i,
    input logic                 req_valid_i,
    input logic [NUM_BANKS-1:0] bank_valid_i,
    input logic                 rsp_valid_i
);
    timeunit 1ns;
    timeprecision 100ps;

    // ----------------------------------------
    // Timing
    // ----------------------------------------
    // Every request answered after the fixed latency
    a_req_to_rsp: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        req_valid_i |-> ##LSU_LATENCY rsp_valid_i)
        else $error("Request got no response after the fixed latency");

    // No response without a request at the right distance
    a_rsp_from_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        rsp_valid_i |-> $past(req_valid_i, LSU_LATENCY))
        else $error("Response without a matching earlier request");

    // Quiet output right after reset
    a_quiet_after_reset: assert property (@(posedge clk_i)
        !rst_n_i |=> !rsp_valid_i ##1 !rsp_valid_i)
        else $error("Response strobe seen just after reset");

    // ----------------------------------------
    // Bank strobes
    // ----------------------------------------
    a_bank_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(bank_valid_i))
        else $error("More than one bank strobed in one cycle");

endmodule

bind lsu_top tb_lsu_properties #(
    .NUM_BANKS (NUM_BANKS)
) u_props (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .req_valid_i  (req_valid_i),
    .bank_valid_i (bank_valid),
    .rsp_valid_i  (rsp_valid_o)
);

/* source/lsu_top.sv */
module lsu_top import lsu_pkg::*; #(
    parameter int unsigned NUM_BANKS  = 4,
    parameter int unsigned BANK_DEPTH = 16,
    parameter int unsigned ADDR_W     = 9
) (
    input  logic     clk_i,
    input  logic     rst_n_i,
    input  logic     req_valid_i,
    input  lsu_req_t req_i,
    output logic     rsp_valid_o,
    output lsu_rsp_t rsp_o
);

    // ---------------------------------------
    // Internal nets
    // ---------------------------------------
    // Dispatch to banks
    logic [NUM_BANKS-1:0]           bank_valid;
    lsu_bank_cmd_t                  bank_cmd;
    // Dispatch side strobe to collector
    logic                           exc_valid;
    lsu_rsp_t                       exc_rsp;
    // Banks to collector
    logic [NUM_BANKS-1:0]           rd_valid;
    logic [NUM_BANKS-1:0][XLEN-1:0] rd_data;

    // Front stage
    lsu_dispatch #(
        .NUM_BANKS (NUM_BANKS),
        .ADDR_W    (ADDR_W)
    ) u_dispatch (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .req_valid_i  (req_valid_i),
        .req_i        (req_i),
        .bank_valid_o (bank_valid),
        .bank_cmd_o   (bank_cmd),
        .exc_valid_o  (exc_valid),
        .exc_rsp_o    (exc_rsp)
    );

    // One bank per doubleword interleave slot
    for (genvar g = 0; g < NUM_BANKS; g++) begin : g_bank
        lsu_bank #(
            .BANK_DEPTH (BANK_DEPTH)
        ) u_bank (
            .clk_i       (clk_i),
            .rst_n_i     (rst_n_i),
            .cmd_valid_i (bank_valid[g]),
            .cmd_i       (bank_cmd),
            .rd_valid_o  (rd_valid[g]),
            .rd_data_o   (rd_data[g])
        );
    end

    // Back stage
    lsu_collector #(
        .NUM_BANKS (NUM_BANKS)
    ) u_collector (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_valid_i  (rd_valid),
        .rd_data_i   (rd_data),
        .exc_valid_i (exc_valid),
        .exc_rsp_i   (exc_rsp),
        .rsp_valid_o (rsp_valid_o),
        .rsp_o       (rsp_o)
    );

endmodule

/* source/lsu_collector.sv */
module lsu_collector import lsu_pkg::*; #(
    parameter int unsigned NUM_BANKS = 4
) (
    input  logic                            clk_i,
    input  logic                            rst_n_i,
    input  logic [NUM_BANKS-1:0]            rd_valid_i,
    input  logic [NUM_BANKS-1:0][XLEN-1:0]  rd_data_i,
    input  logic                            exc_valid_i,
    input  lsu_rsp_t                        exc_rsp_i,
    output logic                            rsp_valid_o,
    output lsu_rsp_t                        rsp_o
);

    // Side path delayed to line up with bank results
    logic            side_valid_q;
    lsu_rsp_t        side_rsp_q;
    logic [XLEN-1:0] merged;
    lsu_rsp_t        rsp_d;

    // ---------------------------------------
    // Side stage
    // ---------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            side_valid_q <= 1'b0;
        end else begin
            side_valid_q <= exc_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (exc_valid_i) begin
            side_rsp_q <= exc_rsp_i;
        end
    end

    // ---------------------------------------
    // Merge
    // ---------------------------------------
    // Banks are one-hot, so an OR of the gated lanes is enough
    always_comb begin
        merged = '0;
        for (int i = 0; i < NUM_BANKS; i++) begin
            if (rd_valid_i[i]) begin
                merged = merged | rd_data_i[i];
            end
        end
    end

    always_comb begin
        rsp_d = side_rsp_q;
        // Data only for good loads
        if (side_rsp_q.is_store || side_rsp_q.misaligned) begin
            rsp_d.rdata = '0;
        end else begin
            rsp_d.rdata = merged;
        end
    end

    // Output stage
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= side_valid_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (side_valid_q) begin
            rsp_o <= rsp_d;
        end
    end

endmodule

/* source/lsu_bank.sv */
module lsu_bank import lsu_pkg::*; #(
    parameter int unsigned BANK_DEPTH = 16
) (
    input  logic            clk_i,
    input  logic            rst_n_i,
    input  logic            cmd_valid_i,
    input  lsu_bank_cmd_t   cmd_i,
    output logic            rd_valid_o,
    output logic [XLEN-1:0] rd_data_o
);

    // Row bits actually used inside this bank
    localparam int unsigned ROW_BITS = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

    logic [XLEN-1:0]       mem [BANK_DEPTH];
    logic [ROW_BITS-1:0]   row;
    logic                  load_hit;
    logic                  store_hit;

    // Load stage registers
    logic                  rd_valid_q;
    logic [XLEN-1:0]       rd_line_q;
    ldst_type_t            rd_type_q;
    logic [BYTE_OFF_W-1:0] rd_off_q;

    assign row       = cmd_i.index[ROW_BITS-1:0];
    assign load_hit  = cmd_valid_i && !cmd_i.is_store;
    assign store_hit = cmd_valid_i && cmd_i.is_store;

    // ---------------------------------------
    // Storage
    // ---------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            // All rows zero after reset
            for (int r = 0; r < BANK_DEPTH; r++) begin
                mem[r] <= '0;
            end
        end else if (store_hit) begin
            // Byte lanes outside the enables keep old contents
            for (int b = 0; b < NUM_BYTES; b++) begin
                if (cmd_i.be[b]) begin
                    mem[row][b*8 +: 8] <= cmd_i.wdata[b*8 +: 8];
                end
            end
        end
    end

    // ---------------------------------------
    // Load path
    // ---------------------------------------
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            rd_valid_q <= 1'b0;
        end else begin
            // Stores give no read strobe
            rd_valid_q <= load_hit;
        end
    end

    // Row data plus what the aligner needs
    always_ff @(posedge clk_i) begin
        if (load_hit) begin
            rd_line_q <= mem[row];
            rd_type_q <= cmd_i.ldst_type;
            rd_off_q  <= cmd_i.byte_off;
        end
    end

    load_aligner u_aligner (
        .ldst_type_i (rd_type_q),
        .byte_off_i  (rd_off_q),
        .line_i      (rd_line_q),
        .line_o      (rd_data_o)
    );

    assign rd_valid_o = rd_valid_q;

endmodule

/* source/lsu_dispatch.sv */
module lsu_dispatch import lsu_pkg::*; #(
    parameter int unsigned NUM_BANKS = 4,
    parameter int unsigned ADDR_W    = 9
) (
    input  logic                 clk_i,
    input  logic                 rst_n_i,
    input  logic                 req_valid_i,
    input  lsu_req_t             req_i,
    output logic [NUM_BANKS-1:0] bank_valid_o,
    output lsu_bank_cmd_t        bank_cmd_o,
    output logic                 exc_valid_o,
    output lsu_rsp_t             exc_rsp_o
);

    // Bank select sits right above the byte offset
    localparam int unsigned BANK_SEL_W = $clog2(NUM_BANKS);
    localparam int unsigned BANK_LSB   = BYTE_OFF_W;
    localparam int unsigned ROW_LSB    = BYTE_OFF_W + BANK_SEL_W;

    logic [BYTE_OFF_W-1:0] byte_off;
    logic [BANK_SEL_W-1:0] bank_sel;
    logic                  misaligned;
    logic [NUM_BYTES-1:0]  size_mask;
    logic [NUM_BANKS-1:0]  bank_onehot;
    lsu_bank_cmd_t         cmd_d;

    assign byte_off = req_i.addr[BYTE_OFF_W-1:0];
    assign bank_sel = req_i.addr[BANK_LSB +: BANK_SEL_W];

    // ---------------------------------------
    // Alignment and size decode
    // ---------------------------------------
    always_comb begin
        misaligned = 1'b0;
        size_mask  = '1;
        case (req_i.ldst_type)
            LS_BYTE, LS_BYTE_U: begin
                size_mask = 8'b0000_0001;
            end
            LS_HALFWORD, LS_HALFWORD_U: begin
                misaligned = byte_off[0];
                size_mask  = 8'b0000_0011;
            end
            LS_WORD, LS_WORD_U: begin
                misaligned = |byte_off[1:0];
                size_mask  = 8'b0000_1111;
            end
            LS_DOUBLEWORD: begin
                misaligned = |byte_off;
            end
            // Unused encoding, full row
            default: ;
        endcase
    end

    // One-hot strobe for the addressed bank
    always_comb begin
        bank_onehot           = '0;
        bank_onehot[bank_sel] = 1'b1;
    end

    // ---------------------------------------
    // Command build
    // ---------------------------------------
    always_comb begin
        cmd_d.is_store  = req_i.is_store;
        cmd_d.ldst_type = req_i.ldst_type;
        cmd_d.byte_off  = byte_off;
        // Row bits above the bank select, zero-extended
        cmd_d.index     = ROW_W'(req_i.addr[ADDR_W-1:ROW_LSB]);
        cmd_d.be        = size_mask << byte_off;
        // Move store data into its byte lanes
        cmd_d.wdata     = req_i.wdata << {byte_off, 3'b000};
    end

    // Strobes
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            bank_valid_o <= '0;
            exc_valid_o  <= 1'b0;
        end else begin
            // No bank access for a bad request
            bank_valid_o <= (req_valid_i && !misaligned) ? bank_onehot : '0;
            // Side strobe for every request
            exc_valid_o  <= req_valid_i;
        end
    end

    // Payload
    always_ff @(posedge clk_i) begin
        if (req_valid_i) begin
            bank_cmd_o           <= cmd_d;
            exc_rsp_o.tag        <= req_i.tag;
            exc_rsp_o.is_store   <= req_i.is_store;
            exc_rsp_o.misaligned <= misaligned;
            exc_rsp_o.rdata      <= '0;
        end
    end

endmodule

/* source/load_aligner.sv */
module load_aligner import lsu_pkg::*; (
    input  ldst_type_t            ldst_type_i,
    input  logic [BYTE_OFF_W-1:0] byte_off_i,
    input  logic [XLEN-1:0]       line_i,
    output logic [XLEN-1:0]       line_o
);

    logic [31:0] sel_w;
    logic [15:0] sel_h;
    logic [7:0]  sel_b;

    // ---------------------------------------
    // Lane selection
    // ---------------------------------------
    always_comb begin
        // Upper or lower word
        if (byte_off_i[2]) begin
            sel_w = line_i[63:32];
        end else begin
            sel_w = line_i[31:0];
        end
        // Upper or lower halfword of it
        if (byte_off_i[1]) begin
            sel_h = sel_w[31:16];
        end else begin
            sel_h = sel_w[15:0];
        end
        // Upper or lower byte of that
        if (byte_off_i[0]) begin
            sel_b = sel_h[15:8];
        end else begin
            sel_b = sel_h[7:0];
        end
    end

    // ---------------------------------------
    // Extension
    // ---------------------------------------
    always_comb begin
        case (ldst_type_i)
            // Signed, replicate top bit
            LS_BYTE:       line_o = {{(XLEN-8){sel_b[7]}}, sel_b};
            LS_HALFWORD:   line_o = {{(XLEN-16){sel_h[15]}}, sel_h};
            LS_WORD:       line_o = {{(XLEN-32){sel_w[31]}}, sel_w};
            // Unsigned, pad with zeros
            LS_BYTE_U:     line_o = {{(XLEN-8){1'b0}}, sel_b};
            LS_HALFWORD_U: line_o = {{(XLEN-16){1'b0}}, sel_h};
            LS_WORD_U:     line_o = {{(XLEN-32){1'b0}}, sel_w};
            // Whole row as is
            LS_DOUBLEWORD: line_o = line_i;
            default:       line_o = line_i;
        endcase
    end

endmodule

/* source/lsu_pkg.sv */
package lsu_pkg;

    // ---------------------------------------
    // Widths
    // ---------------------------------------

    // Data path width
    localparam int unsigned XLEN = 64;
    // Bytes per doubleword
    localparam int unsigned NUM_BYTES = XLEN / 8;
    // Byte offset inside a doubleword
    localparam int unsigned BYTE_OFF_W = 3;
    // Row index field of a bank command
    localparam int unsigned ROW_W = 16;
    // Request tag
    localparam int unsigned TAG_W = 4;
    // Full byte address carried by a request
    localparam int unsigned REQ_ADDR_W = 32;

    // Cycles from request strobe to response strobe
    localparam int unsigned LSU_LATENCY = 3;

    // ---------------------------------------
    // Access type
    // ---------------------------------------

    // Size and signedness of one access
    typedef enum logic [2:0] {
        LS_BYTE       = 3'd0,
        LS_BYTE_U     = 3'd1,
        LS_HALFWORD   = 3'd2,
        LS_HALFWORD_U = 3'd3,
        LS_WORD       = 3'd4,
        LS_WORD_U     = 3'd5,
        LS_DOUBLEWORD = 3'd6
    } ldst_type_t;

    // ---------------------------------------
    // Request, bank command, response
    // ---------------------------------------

    // Incoming request, store data right-aligned
    typedef struct packed {
        ldst_type_t             ldst_type;
        logic                   is_store;
        logic [REQ_ADDR_W-1:0]  addr;
        logic [XLEN-1:0]        wdata;
        logic [TAG_W-1:0]       tag;
    } lsu_req_t;

    // Dispatch to bank, store data already in its byte lanes
    typedef struct packed {
        logic                   is_store;
        ldst_type_t             ldst_type;
        logic [BYTE_OFF_W-1:0]  byte_off;
        logic [ROW_W-1:0]       index;
        logic [NUM_BYTES-1:0]   be;
        logic [XLEN-1:0]        wdata;
    } lsu_bank_cmd_t;

    // Response, data zero for stores and exceptions
    typedef struct packed {
        logic [TAG_W-1:0]       tag;
        logic                   is_store;
        logic                   misaligned;
        logic [XLEN-1:0]        rdata;
    } lsu_rsp_t;

endpackage
